// File: verification/burst_stim.txt
# op addr len burst strobe checksum, all fields hex, burst 0 fixed 1 incr 2 wrap 3 reserved
# checksum ffffffff means the reference model alone gives the expected value
w 00000000 07 1 f ffffffff
r 00000000 07 1 0 ffffffff
w 00000000 03 1 5 ffffffff
r 00000000 03 1 0 ffffffff
w 00000004 03 1 a ffffffff
r 00000000 07 1 0 ffffffff
w 00000040 03 0 f ffffffff
r 00000040 01 0 0 00000000
r 00000040 03 0 0 00000000
w 00000028 03 2 f ffffffff
r 00000028 03 2 0 ffffffff
r 00000020 03 1 0 ffffffff
w 00000060 03 3 f ffffffff
r 00000060 03 1 0 ffffffff
b 00000030 03 1 f ffffffff
r 00000000 00 1 0 ffffffff

// File: all.f
common/axi_burst_pkg.sv
hw/burst_addr_gen.sv
hw/byte_lane_ram.sv
hw/write_channel.sv
hw/read_channel.sv
hw/burst_mem_slave.sv
verification/tb_burst_mem_slave.sv

// File: Bender.yml
package:
  name: burst_mem_slave

sources:
  - common/axi_burst_pkg.sv
  - hw/burst_addr_gen.sv
  - hw/byte_lane_ram.sv
  - hw/write_channel.sv
  - hw/read_channel.sv
  - hw/burst_mem_slave.sv
  - target: simulation
    files:
      - verification/tb_burst_mem_slave.sv

// File: verification/tb_burst_mem_slave.sv
`timescale 1ns/1ns
`default_nettype none

module tb_burst_mem_slave;

	localparam int wait_limit = 200;
	localparam logic [31:0] no_chk = 32'hffff_ffff;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [31:0] S_AXI_AWADDR;
	logic [7:0] S_AXI_AWLEN;
	logic [1:0] S_AXI_AWBURST;
	logic S_AXI_AWVALID;
	logic S_AXI_AWREADY;
	logic [31:0] S_AXI_WDATA;
	logic [3:0] S_AXI_WSTRB;
	logic S_AXI_WLAST;
	logic S_AXI_WVALID;
	logic S_AXI_WREADY;
	logic [1:0] S_AXI_BRESP;
	logic S_AXI_BVALID;
	logic S_AXI_BREADY;
	logic [31:0] S_AXI_ARADDR;
	logic [7:0] S_AXI_ARLEN;
	logic [1:0] S_AXI_ARBURST;
	logic S_AXI_ARVALID;
	logic S_AXI_ARREADY;
	logic [31:0] S_AXI_RDATA;
	logic [1:0] S_AXI_RRESP;
	logic S_AXI_RLAST;
	logic S_AXI_RVALID;
	logic S_AXI_RREADY;

	// Reference memory mirroring every accepted write beat
	logic [31:0] model_mem [0:31];
	logic [31:0] rng;
	int errors;
	int checks;
	bit aborted;
	int ar_grants;
	int ar_base;

	burst_mem_slave #(.data_width(32), .addr_width(32)) u_dut (.*);

	always #4 S_AXI_ACLK = ~S_AXI_ACLK;

	// Every ARREADY pulse is counted so that a read granted while the
	// write response is still pending is not missed
	always @(posedge S_AXI_ACLK) begin
		if (S_AXI_ARREADY) begin
			ar_grants++;
		end
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// FIXED holds the word and WRAP folds back by 4*len; other codes step one word
	function automatic logic [31:0] step_addr(input logic [31:0] a, input logic [7:0] len,
			input logic [1:0] burst);
		logic [31:0] ws;
		logic [31:0] inc;
		ws = 32'(len) * 4;
		inc = {a[31:2] + 30'd1, 2'b00};
		if (burst == 2'b00) begin
			return a;
		end else if (burst == 2'b10) begin
			return ((a & ws) == ws) ? a - ws : inc;
		end
		return inc;
	endfunction

	task automatic compare_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		errors++;
		aborted = 1;
	endtask

	// ----------------------------------------
	// Write burst
	// ----------------------------------------

	task automatic write_burst(input logic [31:0] addr, input logic [7:0] len,
			input logic [1:0] burst, input logic [3:0] strb, input bit with_read);
		logic [31:0] a;
		logic [31:0] d;
		int t;
		int hold;
		if (aborted) return;
		a = addr;
		if (with_read) begin
			ar_base = ar_grants;
		end
		@(posedge S_AXI_ACLK);
		S_AXI_AWADDR <= addr;
		S_AXI_AWLEN <= len;
		S_AXI_AWBURST <= burst;
		S_AXI_AWVALID <= 1'b1;
		// Same cycle read request that has to wait for the write
		if (with_read) begin
			S_AXI_ARADDR <= addr;
			S_AXI_ARLEN <= len;
			S_AXI_ARBURST <= burst;
			S_AXI_ARVALID <= 1'b1;
		end
		t = 0;
		@(negedge S_AXI_ACLK);
		while (!S_AXI_AWREADY && t < wait_limit) begin
			if (with_read) begin
				compare_word("S_AXI_ARREADY", S_AXI_ARREADY, 0);
			end
			@(negedge S_AXI_ACLK);
			t++;
		end
		if (!S_AXI_AWREADY) begin
			report_timeout("AWREADY");
			return;
		end
		for (int i = 0; i <= len; i++) begin
			d = next_rand();
			@(posedge S_AXI_ACLK);
			S_AXI_AWVALID <= 1'b0;
			S_AXI_WDATA <= d;
			S_AXI_WSTRB <= strb;
			S_AXI_WLAST <= (i == len);
			S_AXI_WVALID <= 1'b1;
			t = 0;
			@(negedge S_AXI_ACLK);
			while (!S_AXI_WREADY && t < wait_limit) begin
				@(negedge S_AXI_ACLK);
				t++;
			end
			if (!S_AXI_WREADY) begin
				report_timeout("WREADY");
				return;
			end
			if (with_read) begin
				compare_word("S_AXI_ARREADY", S_AXI_ARREADY, 0);
			end
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) model_mem[a[6:2]][b*8 +: 8] = d[b*8 +: 8];
			end
			a = step_addr(a, len, burst);
		end
		@(posedge S_AXI_ACLK);
		S_AXI_WVALID <= 1'b0;
		S_AXI_WLAST <= 1'b0;
		t = 0;
		@(negedge S_AXI_ACLK);
		while (!S_AXI_BVALID && t < wait_limit) begin
			@(negedge S_AXI_ACLK);
			t++;
		end
		if (!S_AXI_BVALID) begin
			report_timeout("BVALID");
			return;
		end
		// Response must hold while the master stalls
		hold = next_rand() % 4;
		repeat (hold) begin
			@(negedge S_AXI_ACLK);
			compare_word("S_AXI_BVALID", S_AXI_BVALID, 1);
		end
		@(posedge S_AXI_ACLK);
		S_AXI_BREADY <= 1'b1;
		@(negedge S_AXI_ACLK);
		compare_word("S_AXI_BVALID", S_AXI_BVALID, 1);
		compare_word("S_AXI_BRESP", S_AXI_BRESP, 0);
		@(posedge S_AXI_ACLK);
		S_AXI_BREADY <= 1'b0;
	endtask

	// ----------------------------------------
	// Read burst
	// ----------------------------------------

	task automatic read_burst(input logic [31:0] addr, input logic [7:0] len,
			input logic [1:0] burst, input logic [31:0] chk, input bit addr_sent);
		logic [31:0] a;
		logic [31:0] sum;
		logic [31:0] exp_sum;
		logic [31:0] held;
		int t;
		int hold;
		if (aborted) return;
		a = addr;
		sum = '0;
		exp_sum = '0;
		// A request raised together with a write is already on the bus
		if (!addr_sent) begin
			ar_base = ar_grants;
			@(posedge S_AXI_ACLK);
			S_AXI_ARADDR <= addr;
			S_AXI_ARLEN <= len;
			S_AXI_ARBURST <= burst;
			S_AXI_ARVALID <= 1'b1;
		end
		t = 0;
		@(negedge S_AXI_ACLK);
		while (ar_grants == ar_base && t < wait_limit) begin
			@(negedge S_AXI_ACLK);
			t++;
		end
		if (ar_grants == ar_base) begin
			report_timeout("ARREADY");
			return;
		end
		@(posedge S_AXI_ACLK);
		S_AXI_ARVALID <= 1'b0;
		for (int i = 0; i <= len; i++) begin
			t = 0;
			@(negedge S_AXI_ACLK);
			while (!S_AXI_RVALID && t < wait_limit) begin
				// Data bus idles at zero between beats
				compare_word("S_AXI_RDATA", S_AXI_RDATA, 0);
				compare_word("S_AXI_RLAST", S_AXI_RLAST, 0);
				@(negedge S_AXI_ACLK);
				t++;
			end
			if (!S_AXI_RVALID) begin
				report_timeout("RVALID");
				return;
			end
			held = S_AXI_RDATA;
			hold = next_rand() % 4;
			repeat (hold) begin
				@(negedge S_AXI_ACLK);
				compare_word("S_AXI_RVALID", S_AXI_RVALID, 1);
				compare_word("S_AXI_RDATA", S_AXI_RDATA, held);
			end
			@(posedge S_AXI_ACLK);
			S_AXI_RREADY <= 1'b1;
			@(negedge S_AXI_ACLK);
			compare_word("S_AXI_RDATA", S_AXI_RDATA, model_mem[a[6:2]]);
			compare_word("S_AXI_RLAST", S_AXI_RLAST, (i == len));
			compare_word("S_AXI_RRESP", S_AXI_RRESP, 0);
			sum = sum ^ S_AXI_RDATA;
			exp_sum = exp_sum ^ model_mem[a[6:2]];
			a = step_addr(a, len, burst);
			@(posedge S_AXI_ACLK);
			S_AXI_RREADY <= 1'b0;
		end
		compare_word("read checksum", sum, exp_sum);
		if (chk != no_chk) compare_word("stim checksum", sum, chk);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial begin
		int fd;
		int n;
		int tests;
		int errs_before;
		string line;
		byte op;
		logic [31:0] addr;
		logic [31:0] len;
		logic [31:0] burst;
		logic [31:0] strb;
		logic [31:0] chk;
		S_AXI_ACLK = 0;
		S_AXI_ARESETN = 0;
		S_AXI_AWADDR = '0;
		S_AXI_AWLEN = '0;
		S_AXI_AWBURST = '0;
		S_AXI_AWVALID = 0;
		S_AXI_WDATA = '0;
		S_AXI_WSTRB = '0;
		S_AXI_WLAST = 0;
		S_AXI_WVALID = 0;
		S_AXI_BREADY = 0;
		S_AXI_ARADDR = '0;
		S_AXI_ARLEN = '0;
		S_AXI_ARBURST = '0;
		S_AXI_ARVALID = 0;
		S_AXI_RREADY = 0;
		rng = 32'h452b_a1af;
		errors = 0;
		checks = 0;
		tests = 0;
		aborted = 0;
		ar_grants = 0;
		ar_base = 0;
		repeat (2) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
		@(negedge S_AXI_ACLK);
		compare_word("S_AXI_BVALID", S_AXI_BVALID, 0);
		compare_word("S_AXI_RVALID", S_AXI_RVALID, 0);
		compare_word("S_AXI_RLAST", S_AXI_RLAST, 0);
		compare_word("S_AXI_AWREADY", S_AXI_AWREADY, 0);
		compare_word("S_AXI_WREADY", S_AXI_WREADY, 0);
		compare_word("S_AXI_ARREADY", S_AXI_ARREADY, 0);
		fd = $fopen("verification/burst_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			errors++;
		end else begin
			while (!aborted && $fgets(line, fd) != 0) begin
				if (line.len() < 2 || line[0] == "#") continue;
				n = $sscanf(line, "%c %h %h %h %h %h", op, addr, len, burst, strb, chk);
				if (n != 6) begin
					$display("Malformed stimulus line: %s", line);
					errors++;
					continue;
				end
				errs_before = errors;
				tests++;
				if (op == "w") begin
					write_burst(addr, len[7:0], burst[1:0], strb[3:0], 0);
				end else if (op == "r") begin
					read_burst(addr, len[7:0], burst[1:0], chk, 0);
				end else begin
					// Both address channels raised together
					write_burst(addr, len[7:0], burst[1:0], strb[3:0], 1);
					read_burst(addr, len[7:0], burst[1:0], chk, 1);
				end
				$display("test %0d op %c addr %h len %0d burst %0d: %0d errors", tests, op,
					addr, len, burst, errors - errs_before);
			end
			$fclose(fd);
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/burst_mem_slave.sv
`timescale 1ns/1ns
`default_nettype none

module burst_mem_slave #(
	parameter int data_width = axi_burst_pkg::data_width,
	parameter int addr_width = axi_burst_pkg::addr_width
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Write address channel
	input logic [addr_width-1:0] S_AXI_AWADDR,
	input axi_burst_pkg::len_t S_AXI_AWLEN,
	input axi_burst_pkg::burst_t S_AXI_AWBURST,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	// Write data channel
	input logic [data_width-1:0] S_AXI_WDATA,
	input logic [data_width/8-1:0] S_AXI_WSTRB,
	input logic S_AXI_WLAST,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	// Write response channel
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	// Read address channel
	input logic [addr_width-1:0] S_AXI_ARADDR,
	input axi_burst_pkg::len_t S_AXI_ARLEN,
	input axi_burst_pkg::burst_t S_AXI_ARBURST,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	// Read data channel
	output logic [data_width-1:0] S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RLAST,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY
);

	// Ownership of the RAM, only one side holds it at a time
	logic write_busy;
	logic read_busy;

	logic aw_start;
	logic w_beat;
	logic ar_start;
	logic r_beat;
	logic r_final;

	axi_burst_pkg::burst_addr_u w_addr;
	axi_burst_pkg::burst_addr_u r_addr;
	logic [data_width-1:0] rd_word;

	write_channel u_wchan (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.awvalid(S_AXI_AWVALID),
		.wvalid(S_AXI_WVALID),
		.wlast(S_AXI_WLAST),
		.bready(S_AXI_BREADY),
		.read_busy(read_busy),
		.awready(S_AXI_AWREADY),
		.wready(S_AXI_WREADY),
		.bvalid(S_AXI_BVALID),
		.bresp(S_AXI_BRESP),
		.aw_start(aw_start),
		.w_beat(w_beat),
		.write_busy(write_busy)
	);

	read_channel #(.data_width(data_width)) u_rchan (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.arvalid(S_AXI_ARVALID),
		.awvalid(S_AXI_AWVALID),
		.rready(S_AXI_RREADY),
		.write_busy(write_busy),
		.r_final(r_final),
		.rd_word(rd_word),
		.arready(S_AXI_ARREADY),
		.rvalid(S_AXI_RVALID),
		.rlast(S_AXI_RLAST),
		.rresp(S_AXI_RRESP),
		.rdata(S_AXI_RDATA),
		.ar_start(ar_start),
		.r_beat(r_beat),
		.read_busy(read_busy)
	);

	// Write bursts end on WLAST, so the beat count compare stays open
	burst_addr_gen #(.data_width(data_width), .addr_width(addr_width)) u_waddr (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.start(aw_start),
		.beat(w_beat),
		.addr_in(S_AXI_AWADDR),
		.len_in(S_AXI_AWLEN),
		.burst_in(S_AXI_AWBURST),
		.addr(w_addr),
		.final_beat()
	);

	burst_addr_gen #(.data_width(data_width), .addr_width(addr_width)) u_raddr (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.start(ar_start),
		.beat(r_beat),
		.addr_in(S_AXI_ARADDR),
		.len_in(S_AXI_ARLEN),
		.burst_in(S_AXI_ARBURST),
		.addr(r_addr),
		.final_beat(r_final)
	);

	byte_lane_ram #(.data_width(data_width)) u_ram (
		.S_AXI_ACLK(S_AXI_ACLK),
		.w_addr(w_addr),
		.r_addr(r_addr),
		.write_busy(write_busy),
		.read_busy(read_busy),
		.we(w_beat),
		.wdata(S_AXI_WDATA),
		.wstrb(S_AXI_WSTRB),
		.rd_word(rd_word)
	);

endmodule

`default_nettype wire

// File: hw/read_channel.sv
`timescale 1ns/1ns
`default_nettype none

module read_channel #(
	parameter int data_width = axi_burst_pkg::data_width
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic arvalid,
	input logic awvalid,
	input logic rready,
	input logic write_busy,
	input logic r_final,
	input logic [data_width-1:0] rd_word,
	output logic arready,
	output logic rvalid,
	output logic rlast,
	output logic [1:0] rresp,
	output logic [data_width-1:0] rdata,
	output logic ar_start,
	output logic r_beat,
	output logic read_busy
);

	// ----------------------------------------
	// Address acceptance
	// ----------------------------------------

	// A pending write address wins over a read in the same cycle
	assign ar_start = ~arready & arvalid & ~write_busy & ~read_busy & ~awvalid;

	// Beat is taken by the master
	assign r_beat = rvalid & rready;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			arready <= 1'b0;
			read_busy <= 1'b0;
		end else begin
			arready <= ar_start;
			if (ar_start) begin
				read_busy <= 1'b1;
			end else if (r_beat && r_final) begin
				// Last beat gone so the RAM is free again
				read_busy <= 1'b0;
			end
		end
	end

	// ----------------------------------------
	// Read valid and last
	// ----------------------------------------

	// RVALID comes up on the same edge that registers the RAM word.
	// The low cycle after each beat gives the RAM time to fetch
	// the word at the stepped address
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			rvalid <= 1'b0;
			rlast <= 1'b0;
		end else if (read_busy && ~rvalid) begin
			rvalid <= 1'b1;
			// Beat count already points at the beat being presented
			rlast <= r_final;
		end else if (r_beat) begin
			rvalid <= 1'b0;
			rlast <= 1'b0;
		end
	end

	// ----------------------------------------
	// Read data
	// ----------------------------------------

	// Bus reads zero outside a valid beat
	assign rdata = rvalid ? rd_word : '0;

	// Reads always succeed
	assign rresp = axi_burst_pkg::resp_okay;

endmodule

`default_nettype wire

// File: hw/write_channel.sv
`timescale 1ns/1ns
`default_nettype none

module write_channel (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic awvalid,
	input logic wvalid,
	input logic wlast,
	input logic bready,
	input logic read_busy,
	output logic awready,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	output logic aw_start,
	output logic w_beat,
	output logic write_busy
);

	// ----------------------------------------
	// Address acceptance
	// ----------------------------------------

	// Grant needs an idle RAM; a read already running blocks it
	assign aw_start = ~awready & awvalid & ~write_busy & ~read_busy;

	// Data beat moves when both sides agree
	assign w_beat = wready & wvalid;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			awready <= 1'b0;
			write_busy <= 1'b0;
		end else begin
			// One cycle pulse, the busy flag keeps the grant low afterwards
			awready <= aw_start;
			if (aw_start) begin
				write_busy <= 1'b1;
			end else if (w_beat && wlast) begin
				// Burst done, free the RAM
				write_busy <= 1'b0;
			end
		end
	end

	// ----------------------------------------
	// Data ready
	// ----------------------------------------

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			wready <= 1'b0;
		end else if (~wready && wvalid && write_busy) begin
			wready <= 1'b1;
		end else if (w_beat && wlast) begin
			wready <= 1'b0;
		end
	end

	// ----------------------------------------
	// Write response
	// ----------------------------------------

	// Held until the master takes it
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			bvalid <= 1'b0;
		end else if (w_beat && wlast && ~bvalid) begin
			bvalid <= 1'b1;
		end else if (bvalid && bready) begin
			bvalid <= 1'b0;
		end
	end

	// Every write completes without error
	assign bresp = axi_burst_pkg::resp_okay;

endmodule

`default_nettype wire

// File: hw/byte_lane_ram.sv
`timescale 1ns/1ns
`default_nettype none

module byte_lane_ram #(
	parameter int data_width = axi_burst_pkg::data_width
) (
	input logic S_AXI_ACLK,
	input axi_burst_pkg::burst_addr_u w_addr,
	input axi_burst_pkg::burst_addr_u r_addr,
	input logic write_busy,
	input logic read_busy,
	input logic we,
	input logic [data_width-1:0] wdata,
	input logic [data_width/8-1:0] wstrb,
	output logic [data_width-1:0] rd_word
);

	localparam int depth = 2 ** axi_burst_pkg::mem_index_bits;
	localparam int lanes = data_width / 8;

	logic [axi_burst_pkg::mem_index_bits-1:0] index;

	// Storage, one byte per lane per word
	logic [data_width-1:0] mem [0:depth-1];

	// ----------------------------------------
	// Word select
	// ----------------------------------------

	// Reader first, then writer, otherwise word 0
	always_comb begin
		if (read_busy) begin
			index = r_addr.fields.index;
		end else if (write_busy) begin
			index = w_addr.fields.index;
		end else begin
			index = '0;
		end
	end

	// ----------------------------------------
	// Write lanes and read register
	// ----------------------------------------

	always_ff @(posedge S_AXI_ACLK) begin
		// Only strobed lanes change
		for (int b = 0; b < lanes; b++) begin
			if (we && wstrb[b]) begin
				mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
			end
		end
		// Refetched every cycle of a read burst
		if (read_busy) begin
			rd_word <= mem[index];
		end
	end

endmodule

`default_nettype wire

// File: hw/burst_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

module burst_addr_gen #(
	parameter int data_width = axi_burst_pkg::data_width,
	parameter int addr_width = axi_burst_pkg::addr_width
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic start,
	input logic beat,
	input logic [addr_width-1:0] addr_in,
	input axi_burst_pkg::len_t len_in,
	input axi_burst_pkg::burst_t burst_in,
	output axi_burst_pkg::burst_addr_u addr,
	output logic final_beat
);

	// Byte offset bits of one beat, 2 for 32 bit and 3 for 64 bit
	localparam int lsb = $clog2(data_width / 8);

	axi_burst_pkg::len_t len_q;
	axi_burst_pkg::len_t beat_cnt;
	axi_burst_pkg::burst_t burst_q;

	logic [addr_width-1:0] wrap_size;
	logic wrap_hit;
	logic [addr_width-1:0] incr_addr;
	logic [addr_width-1:0] next_addr;

	// ----------------------------------------
	// Next address
	// ----------------------------------------

	// Bytes covered by len beats
	assign wrap_size = addr_width'(data_width / 8) * addr_width'(len_q);
	assign wrap_hit = (addr.raw & wrap_size) == wrap_size;

	// Next word, offset dropped so unaligned starts realign
	assign incr_addr = {addr.raw[addr_width-1:lsb] + 1'b1, lsb'(0)};

	always_comb begin
		case (burst_q)
			axi_burst_pkg::burst_wrap: begin
				// Back to the start of the wrap block
				next_addr = wrap_hit ? addr.raw - wrap_size : incr_addr;
			end
			axi_burst_pkg::burst_incr, axi_burst_pkg::burst_rsvd: begin
				next_addr = incr_addr;
			end
			default: begin
				// FIXED burst, every beat hits one word
				next_addr = addr.raw;
			end
		endcase
	end

	// ----------------------------------------
	// Burst state
	// ----------------------------------------

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			len_q <= '0;
			beat_cnt <= '0;
			burst_q <= axi_burst_pkg::burst_fixed;
		end else if (start) begin
			len_q <= len_in;
			beat_cnt <= '0;
			burst_q <= burst_in;
		end else if (beat) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (start) begin
			addr.raw <= addr_in;
		end else if (beat) begin
			addr.raw <= next_addr;
		end
	end

	assign final_beat = beat_cnt == len_q;

endmodule

`default_nettype wire

// File: common/axi_burst_pkg.sv
`default_nettype none

package axi_burst_pkg;

	// ----------------------------------------
	// Bus widths
	// ----------------------------------------

	// One beat is one word of the data bus
	localparam int data_width = 32;
	localparam int addr_width = 32;
	localparam int strb_width = data_width / 8;

	// Byte offset bits inside one beat
	localparam int addr_lsb = 2;

	// 32 words of storage behind the slave
	localparam int mem_index_bits = 5;

	// ----------------------------------------
	// Burst control fields
	// ----------------------------------------

	// Beats in the burst minus one
	typedef logic [7:0] len_t;

	typedef logic [1:0] burst_t;

	localparam burst_t burst_fixed = 2'b00;
	localparam burst_t burst_incr = 2'b01;
	localparam burst_t burst_wrap = 2'b10;
	// Reserved code, stepped like INCR here
	localparam burst_t burst_rsvd = 2'b11;

	// Only response this slave ever returns
	localparam logic [1:0] resp_okay = 2'b00;

	// Latched burst address, used as a plain byte address for stepping
	// and split into word index and byte offset for the RAM select
	typedef union packed {
		logic [addr_width-1:0] raw;
		struct packed {
			logic [addr_width-mem_index_bits-addr_lsb-1:0] upper;
			logic [mem_index_bits-1:0] index;
			logic [addr_lsb-1:0] offset;
		} fields;
	} burst_addr_u;

endpackage

`default_nettype wire
